// File: common/cache_pkg.sv
// cache geometry, address field widths and controller states, imported by the cache RTL and testbench
package cache_pkg;

  // organization
  localparam int num_way = 4;
  localparam int num_set = 8;

  // address split, byte offset / set index / tag
  localparam int offset_bits = 3;
  localparam int index_bits  = 3;
  localparam int tag_bits    = 10;

  // one 64-bit word per line
  localparam int line_bits = 64;

  // miss handling walks wb_req/wb_resp only for a dirty victim
  typedef enum logic [2:0] {
    idle,
    lookup,
    wb_req,
    wb_resp,
    fill_req,
    fill_resp,
    update,
    respond
  } ctrl_state_e;

endpackage

// File: common/axil_pkg.sv
// AXI4-Lite bus widths and response codes shared by both ports of the cache and the testbench
package axil_pkg;

  localparam int addr_bits = 16;
  localparam int data_bits = 64;
  localparam int strb_bits = data_bits / 8;

  // standard xRESP encoding
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } axil_resp_e;

endpackage

// File: dcache/cache_way.sv
// one cache way with per-set valid, dirty, tag and data and a tag compare, used four times by the array
`timescale 1ns/10ps

module cache_way import cache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [index_bits-1:0] index,
  input  logic [tag_bits-1:0]   tag,
  input  logic                  write_en,
  input  logic [line_bits-1:0]  write_data,
  input  logic                  write_dirty,
  output logic                  hit,
  output logic                  line_valid,
  output logic                  line_dirty,
  output logic [tag_bits-1:0]   line_tag,
  output logic [line_bits-1:0]  line_data
);

  logic [num_set-1:0]   valid_q;
  logic [num_set-1:0]   dirty_q;
  logic [tag_bits-1:0]  tag_q [num_set];
  logic [line_bits-1:0] data_q [num_set];

  // status bits, all lines invalid out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (write_en) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= write_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      tag_q[index]  <= tag;
      data_q[index] <= write_data;
    end
  end

  assign line_valid = valid_q[index];
  assign line_dirty = dirty_q[index];
  assign line_tag   = tag_q[index];
  assign line_data  = data_q[index];

  assign hit = line_valid && (line_tag == tag);

endmodule

// File: dcache/dcache_array.sv
// four-way tag and data array with tree pseudo-LRU per set, driven by the cache controller
`timescale 1ns/10ps

module dcache_array import cache_pkg::*; (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic [tag_bits+index_bits+offset_bits-1:0]   lookup_addr,
  input  logic                                         write_en,
  input  logic                                         fill_en,
  input  logic [line_bits-1:0]                         write_data,
  input  logic                                         write_dirty,
  output logic                                         hit,
  output logic [line_bits-1:0]                         hit_data,
  output logic                                         victim_valid,
  output logic                                         victim_dirty,
  output logic [tag_bits+index_bits+offset_bits-1:0]   victim_addr,
  output logic [line_bits-1:0]                         victim_data
);

  logic [index_bits-1:0]      index;
  logic [tag_bits-1:0]        tag;
  logic [num_way-1:0]         way_hit;
  logic [num_way-1:0]         way_valid;
  logic [num_way-1:0]         way_dirty;
  logic [num_way-1:0]         way_we;
  logic [tag_bits-1:0]        way_tag [num_way];
  logic [line_bits-1:0]       way_data [num_way];
  logic [num_set-1:0]         plru_root;
  logic [num_set-1:0]         plru_left;
  logic [num_set-1:0]         plru_right;
  logic [$clog2(num_way)-1:0] victim_way;

  assign index = lookup_addr[offset_bits +: index_bits];
  assign tag   = lookup_addr[offset_bits+index_bits +: tag_bits];

  // root picks the half, left/right bit picks the way within it
  always_comb begin
    if (plru_root[index]) begin
      victim_way = plru_right[index] ? 2'd3 : 2'd2;
    end else begin
      victim_way = plru_left[index] ? 2'd1 : 2'd0;
    end
  end

  // tree only moves on a fill, hits leave it alone
  always_ff @(posedge clock) begin
    if (reset) begin
      plru_root  <= '0;
      plru_left  <= '0;
      plru_right <= '0;
    end else if (fill_en) begin
      if (plru_root[index]) begin
        plru_right[index] <= ~plru_right[index];
      end else begin
        plru_left[index] <= ~plru_left[index];
      end
      plru_root[index] <= ~plru_root[index];
    end
  end

  for (genvar w = 0; w < num_way; w++) begin : g_way
    // stores go to the hit way, fills to the victim way
    assign way_we[w] = (write_en && way_hit[w]) || (fill_en && (int'(victim_way) == w));

    cache_way u_way (
      .clock       (clock),
      .reset       (reset),
      .index       (index),
      .tag         (tag),
      .write_en    (way_we[w]),
      .write_data  (write_data),
      .write_dirty (write_dirty),
      .hit         (way_hit[w]),
      .line_valid  (way_valid[w]),
      .line_dirty  (way_dirty[w]),
      .line_tag    (way_tag[w]),
      .line_data   (way_data[w])
    );
  end

  assign hit = |way_hit;

  // at most one way hits, so an or of the masked lines is enough
  always_comb begin
    hit_data = '0;
    for (int w = 0; w < num_way; w++) begin
      if (way_hit[w]) begin
        hit_data = hit_data | way_data[w];
      end
    end
  end

  assign victim_valid = way_valid[victim_way];
  assign victim_dirty = way_dirty[victim_way];
  assign victim_data  = way_data[victim_way];
  assign victim_addr  = {way_tag[victim_way], index, {offset_bits{1'b0}}};

endmodule

// File: dcache/dcache_ctrl.sv
// cache controller FSM bridging the processor AXI4-Lite slave and the memory AXI4-Lite master
`timescale 1ns/10ps

module dcache_ctrl import cache_pkg::*, axil_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // processor side
  input  logic [addr_bits-1:0] cpu_araddr,
  input  logic                 cpu_arvalid,
  output logic                 cpu_arready,
  output logic [data_bits-1:0] cpu_rdata,
  output axil_resp_e           cpu_rresp,
  output logic                 cpu_rvalid,
  input  logic                 cpu_rready,
  input  logic [addr_bits-1:0] cpu_awaddr,
  input  logic                 cpu_awvalid,
  output logic                 cpu_awready,
  input  logic [data_bits-1:0] cpu_wdata,
  input  logic [strb_bits-1:0] cpu_wstrb,
  input  logic                 cpu_wvalid,
  output logic                 cpu_wready,
  output axil_resp_e           cpu_bresp,
  output logic                 cpu_bvalid,
  input  logic                 cpu_bready,
  // memory side
  output logic [addr_bits-1:0] mem_araddr,
  output logic                 mem_arvalid,
  input  logic                 mem_arready,
  input  logic [data_bits-1:0] mem_rdata,
  input  axil_resp_e           mem_rresp,
  input  logic                 mem_rvalid,
  output logic                 mem_rready,
  output logic [addr_bits-1:0] mem_awaddr,
  output logic                 mem_awvalid,
  input  logic                 mem_awready,
  output logic [data_bits-1:0] mem_wdata,
  output logic [strb_bits-1:0] mem_wstrb,
  output logic                 mem_wvalid,
  input  logic                 mem_wready,
  input  axil_resp_e           mem_bresp,
  input  logic                 mem_bvalid,
  output logic                 mem_bready,
  // toward the array
  output logic [addr_bits-1:0] lookup_addr,
  output logic                 write_en,
  output logic                 fill_en,
  output logic [line_bits-1:0] write_data,
  output logic                 write_dirty,
  input  logic                 hit,
  input  logic [line_bits-1:0] hit_data,
  input  logic                 victim_valid,
  input  logic                 victim_dirty,
  input  logic [addr_bits-1:0] victim_addr,
  input  logic [line_bits-1:0] victim_data
);

  ctrl_state_e          state;
  logic [addr_bits-1:0] req_addr;
  logic                 req_write;
  logic [data_bits-1:0] req_wdata;
  logic [strb_bits-1:0] req_wstrb;
  logic [line_bits-1:0] line_buf;
  axil_resp_e           resp_q;
  logic                 filling;
  logic                 aw_pend;
  logic                 w_pend;
  logic                 ar_fire;
  logic                 wr_fire;
  logic                 rsp_fire;

  function automatic logic [line_bits-1:0] merge_bytes(
    input logic [line_bits-1:0] base,
    input logic [data_bits-1:0] data,
    input logic [strb_bits-1:0] strb
  );
    logic [line_bits-1:0] merged;
    merged = base;
    for (int b = 0; b < strb_bits; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  assign cpu_arready = (state == idle);
  // aw and w only together, and a pending read goes first
  assign cpu_awready = (state == idle) && !cpu_arvalid && (cpu_awvalid == cpu_wvalid);
  assign cpu_wready  = cpu_awready;

  assign ar_fire  = cpu_arvalid && cpu_arready;
  assign wr_fire  = cpu_awvalid && cpu_wvalid && cpu_awready;
  assign rsp_fire = (cpu_rvalid && cpu_rready) || (cpu_bvalid && cpu_bready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= idle;
      req_write <= 1'b0;
      filling   <= 1'b0;
      aw_pend   <= 1'b0;
      w_pend    <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (ar_fire) begin
            req_write <= 1'b0;
            state     <= lookup;
          end else if (wr_fire) begin
            req_write <= 1'b1;
            state     <= lookup;
          end
        end
        lookup: begin
          filling <= !hit;
          if (hit) begin
            state <= req_write ? update : respond;
          end else if (victim_valid && victim_dirty) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
            state   <= wb_req;
          end else begin
            state <= fill_req;
          end
        end
        wb_req: begin
          // aw and w may be taken in different cycles
          if (mem_awready) begin
            aw_pend <= 1'b0;
          end
          if (mem_wready) begin
            w_pend <= 1'b0;
          end
          if ((!aw_pend || mem_awready) && (!w_pend || mem_wready)) begin
            state <= wb_resp;
          end
        end
        wb_resp: begin
          if (mem_bvalid) begin
            state <= (mem_bresp == okay) ? fill_req : respond;
          end
        end
        fill_req: begin
          if (mem_arready) begin
            state <= fill_resp;
          end
        end
        fill_resp: begin
          // error response skips the install
          if (mem_rvalid) begin
            state <= (mem_rresp == okay) ? update : respond;
          end
        end
        update: state <= respond;
        respond: begin
          if (rsp_fire) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // request and line payload
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      req_addr <= cpu_araddr;
    end else if (wr_fire) begin
      req_addr  <= cpu_awaddr;
      req_wdata <= cpu_wdata;
      req_wstrb <= cpu_wstrb;
    end
    if (state == lookup) begin
      line_buf <= hit_data;
      resp_q   <= okay;
    end
    if ((state == wb_resp) && mem_bvalid) begin
      resp_q <= mem_bresp;
    end
    if ((state == fill_resp) && mem_rvalid) begin
      line_buf <= mem_rdata;
      resp_q   <= mem_rresp;
    end
  end

  assign cpu_rvalid = (state == respond) && !req_write;
  assign cpu_bvalid = (state == respond) && req_write;
  assign cpu_rdata  = line_buf;
  assign cpu_rresp  = resp_q;
  assign cpu_bresp  = resp_q;

  // refill of the whole word
  assign mem_arvalid = (state == fill_req);
  assign mem_araddr  = {req_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
  assign mem_rready  = (state == fill_resp);

  // victim stays put in the array until the update state
  assign mem_awvalid = aw_pend;
  assign mem_awaddr  = victim_addr;
  assign mem_wvalid  = w_pend;
  assign mem_wdata   = victim_data;
  assign mem_wstrb   = '1;
  assign mem_bready  = (state == wb_resp);

  assign lookup_addr = req_addr;
  assign write_en    = (state == update) && !filling;
  assign fill_en     = (state == update) && filling;
  assign write_data  = req_write ? merge_bytes(line_buf, req_wdata, req_wstrb) : line_buf;
  assign write_dirty = req_write;

endmodule

// File: source/dcache_top.sv
// data cache top level joining controller and array, the DUT seen by the testbench
`timescale 1ns/10ps

module dcache_top import cache_pkg::*, axil_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [addr_bits-1:0] cpu_araddr,
  input  logic                 cpu_arvalid,
  output logic                 cpu_arready,
  output logic [data_bits-1:0] cpu_rdata,
  output axil_resp_e           cpu_rresp,
  output logic                 cpu_rvalid,
  input  logic                 cpu_rready,
  input  logic [addr_bits-1:0] cpu_awaddr,
  input  logic                 cpu_awvalid,
  output logic                 cpu_awready,
  input  logic [data_bits-1:0] cpu_wdata,
  input  logic [strb_bits-1:0] cpu_wstrb,
  input  logic                 cpu_wvalid,
  output logic                 cpu_wready,
  output axil_resp_e           cpu_bresp,
  output logic                 cpu_bvalid,
  input  logic                 cpu_bready,
  output logic [addr_bits-1:0] mem_araddr,
  output logic                 mem_arvalid,
  input  logic                 mem_arready,
  input  logic [data_bits-1:0] mem_rdata,
  input  axil_resp_e           mem_rresp,
  input  logic                 mem_rvalid,
  output logic                 mem_rready,
  output logic [addr_bits-1:0] mem_awaddr,
  output logic                 mem_awvalid,
  input  logic                 mem_awready,
  output logic [data_bits-1:0] mem_wdata,
  output logic [strb_bits-1:0] mem_wstrb,
  output logic                 mem_wvalid,
  input  logic                 mem_wready,
  input  axil_resp_e           mem_bresp,
  input  logic                 mem_bvalid,
  output logic                 mem_bready
);

  // controller to array
  logic [addr_bits-1:0] lookup_addr;
  logic                 write_en;
  logic                 fill_en;
  logic [line_bits-1:0] write_data;
  logic                 write_dirty;
  // array back to controller
  logic                 hit;
  logic [line_bits-1:0] hit_data;
  logic                 victim_valid;
  logic                 victim_dirty;
  logic [addr_bits-1:0] victim_addr;
  logic [line_bits-1:0] victim_data;

  // all port names match the local names
  dcache_ctrl u_ctrl (.*);

  dcache_array u_array (.*);

endmodule

// File: verification/dcache_chk.sv
// handshake assertions for the cache controller, attached to every dcache_ctrl by bind
`timescale 1ns/10ps

module dcache_chk import cache_pkg::*, axil_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input ctrl_state_e          state,
  input logic                 cpu_arvalid,
  input logic                 cpu_arready,
  input logic                 cpu_rvalid,
  input logic                 cpu_rready,
  input logic [data_bits-1:0] cpu_rdata,
  input axil_resp_e           cpu_rresp,
  input logic                 cpu_awvalid,
  input logic                 cpu_awready,
  input logic                 cpu_wvalid,
  input logic                 cpu_wready,
  input logic                 cpu_bvalid,
  input logic                 cpu_bready,
  input axil_resp_e           cpu_bresp,
  input logic                 mem_arvalid,
  input logic                 mem_awvalid
);

  // read payload held until taken
  r_stable: assert property (@(posedge clock) disable iff (reset)
    cpu_rvalid && !cpu_rready |=> cpu_rvalid && $stable(cpu_rdata) && $stable(cpu_rresp))
    else $error("cpu r payload changed while stalled");

  b_stable: assert property (@(posedge clock) disable iff (reset)
    cpu_bvalid && !cpu_bready |=> cpu_bvalid && $stable(cpu_bresp))
    else $error("cpu b payload changed while stalled");

  // refill and writeback never overlap
  mem_excl: assert property (@(posedge clock) disable iff (reset)
    !(mem_arvalid && mem_awvalid))
    else $error("mem ar and aw valid together");

  // an accepted request takes the FSM out of idle and drops every ready
  busy_ready: assert property (@(posedge clock) disable iff (reset)
    (cpu_arvalid && cpu_arready) || (cpu_awvalid && cpu_wvalid && cpu_awready)
    |=> (state != idle) && !cpu_arready && !cpu_awready && !cpu_wready)
    else $error("cpu request ready right after an accept");

endmodule

bind dcache_ctrl dcache_chk u_chk (.*);

// File: verification/dcache_tb.sv
// self-checking testbench for the data cache, with memory model and reference model
`timescale 1ns/10ps

module dcache_tb import cache_pkg::*, axil_pkg::*; ();

  logic                 clock;
  logic                 reset;
  logic [addr_bits-1:0] cpu_araddr;
  logic                 cpu_arvalid;
  logic                 cpu_arready;
  logic [data_bits-1:0] cpu_rdata;
  axil_resp_e           cpu_rresp;
  logic                 cpu_rvalid;
  logic                 cpu_rready;
  logic [addr_bits-1:0] cpu_awaddr;
  logic                 cpu_awvalid;
  logic                 cpu_awready;
  logic [data_bits-1:0] cpu_wdata;
  logic [strb_bits-1:0] cpu_wstrb;
  logic                 cpu_wvalid;
  logic                 cpu_wready;
  axil_resp_e           cpu_bresp;
  logic                 cpu_bvalid;
  logic                 cpu_bready;
  logic [addr_bits-1:0] mem_araddr;
  logic                 mem_arvalid;
  logic                 mem_arready;
  logic [data_bits-1:0] mem_rdata;
  axil_resp_e           mem_rresp;
  logic                 mem_rvalid;
  logic                 mem_rready;
  logic [addr_bits-1:0] mem_awaddr;
  logic                 mem_awvalid;
  logic                 mem_awready;
  logic [data_bits-1:0] mem_wdata;
  logic [strb_bits-1:0] mem_wstrb;
  logic                 mem_wvalid;
  logic                 mem_wready;
  axil_resp_e           mem_bresp;
  logic                 mem_bvalid;
  logic                 mem_bready;

  // backing store in the memory model, shadow is what the processor must see
  logic [line_bits-1:0] mem_words [8192];
  logic [line_bits-1:0] shadow [8192];
  // reference copy of the cache tags and tree bits
  bit                   m_valid [num_set][num_way];
  bit                   m_dirty [num_set][num_way];
  logic [tag_bits-1:0]  m_tag [num_set][num_way];
  bit                   p_root [num_set];
  bit                   p_left [num_set];
  bit                   p_right [num_set];
  int                   rd_count;
  logic [addr_bits-1:0] rd_addr;
  logic [addr_bits-1:0] wb_addr_q [$];
  logic [line_bits-1:0] wb_data_q [$];
  logic [strb_bits-1:0] wb_strb_q [$];
  bit                   err_en;
  logic [12:0]          err_word;
  bit                   bp_en;
  logic [31:0]          seed;
  int                   errors;
  int                   checks;
  int                   tests;
  int                   test_start_errors;

  dcache_top dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // fill pattern built from every address bit
  function automatic logic [line_bits-1:0] init_word(input logic [12:0] w);
    logic [15:0] a;
    a = {3'b000, w};
    return {a * 16'h0107, a ^ 16'ha5c3, ~a, a};
  endfunction

  function automatic logic [line_bits-1:0] apply_strobe(input logic [line_bits-1:0] base,
      input logic [data_bits-1:0] data, input logic [strb_bits-1:0] strb);
    logic [line_bits-1:0] r;
    r = base;
    for (int b = 0; b < strb_bits; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  // tree pseudo-LRU victim, root selects the half
  function automatic int pick_victim(input int s);
    if (p_root[s]) begin
      return p_right[s] ? 3 : 2;
    end
    return p_left[s] ? 1 : 0;
  endfunction

  task automatic advance_tree(input int s);
    if (p_root[s]) begin
      p_right[s] = !p_right[s];
    end else begin
      p_left[s] = !p_left[s];
    end
    p_root[s] = !p_root[s];
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic report_wrong(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic check_data(input string name, input logic [line_bits-1:0] got,
      input logic [line_bits-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_bits-1:0] got,
      input logic [addr_bits-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input logic [strb_bits-1:0] got,
      input logic [strb_bits-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // memory side slave with random stalls
  initial begin
    int stall;
    int n;
    mem_arready = 1'b0;
    mem_rdata = '0;
    mem_rresp = okay;
    mem_rvalid = 1'b0;
    mem_awready = 1'b0;
    mem_wready = 1'b0;
    mem_bresp = okay;
    mem_bvalid = 1'b0;
    forever begin
      @(negedge clock);
      if (mem_arvalid) begin
        stall = 1 + int'(lcg_next() % 3);
        repeat (stall) @(negedge clock);
        mem_arready = 1'b1;
        rd_addr = mem_araddr;
        rd_count++;
        @(negedge clock);
        mem_arready = 1'b0;
        repeat (stall) @(negedge clock);
        if (err_en && rd_addr[15:3] == err_word) begin
          mem_rresp = slverr;
          mem_rdata = '0;
        end else begin
          mem_rresp = okay;
          mem_rdata = mem_words[rd_addr[15:3]];
        end
        mem_rvalid = 1'b1;
        n = 0;
        while (!mem_rready) begin
          @(negedge clock);
          n++;
          if (n > 100) abort_on_timeout("mem_rready");
        end
        @(negedge clock);
        mem_rvalid = 1'b0;
      end else if (mem_awvalid && mem_wvalid) begin
        stall = 1 + int'(lcg_next() % 3);
        repeat (stall) @(negedge clock);
        mem_awready = 1'b1;
        mem_wready = 1'b1;
        wb_addr_q.push_back(mem_awaddr);
        wb_data_q.push_back(mem_wdata);
        wb_strb_q.push_back(mem_wstrb);
        mem_words[mem_awaddr[15:3]] = mem_wdata;
        @(negedge clock);
        mem_awready = 1'b0;
        mem_wready = 1'b0;
        mem_bresp = okay;
        mem_bvalid = 1'b1;
        n = 0;
        while (!mem_bready) begin
          @(negedge clock);
          n++;
          if (n > 100) abort_on_timeout("mem_bready");
        end
        @(negedge clock);
        mem_bvalid = 1'b0;
      end
    end
  end

  // one processor access, predicted by the reference model and compared on completion
  task automatic do_access(input bit wr, input logic [addr_bits-1:0] addr,
      input logic [data_bits-1:0] data, input logic [strb_bits-1:0] strb, output int lat);
    int s;
    int hw;
    int v;
    int n;
    int reads0;
    bit exp_wb;
    bit err;
    bit got;
    logic [tag_bits-1:0] tag;
    logic [12:0] widx;
    logic [addr_bits-1:0] wb_addr;
    logic [line_bits-1:0] got_data;
    axil_resp_e got_resp;
    axil_resp_e exp_resp;
    s = int'(addr[5:3]);
    tag = addr[15:6];
    widx = addr[15:3];
    hw = -1;
    v = 0;
    for (int w = 0; w < num_way; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == tag) hw = w;
    end
    exp_wb = 1'b0;
    if (hw < 0) begin
      v = pick_victim(s);
      exp_wb = m_valid[s][v] && m_dirty[s][v];
    end
    wb_addr = {m_tag[s][v], addr[5:3], 3'b000};
    err = (hw < 0) && err_en && (widx == err_word);
    exp_resp = err ? slverr : okay;
    reads0 = rd_count;
    wb_addr_q.delete();
    wb_data_q.delete();
    wb_strb_q.delete();
    n = 0;
    @(negedge clock);
    while (!cpu_arready) begin
      @(negedge clock);
      n++;
      if (n > 200) abort_on_timeout("cpu request ready");
    end
    if (wr) begin
      check_flag("cpu_awready", cpu_awready, 1'b1);
      check_flag("cpu_wready", cpu_wready, 1'b1);
      cpu_awaddr = addr;
      cpu_wdata = data;
      cpu_wstrb = strb;
      cpu_awvalid = 1'b1;
      cpu_wvalid = 1'b1;
    end else begin
      cpu_araddr = addr;
      cpu_arvalid = 1'b1;
    end
    @(posedge clock);
    lat = 1;
    got = 1'b0;
    while (!got) begin
      @(negedge clock);
      cpu_arvalid = 1'b0;
      cpu_awvalid = 1'b0;
      cpu_wvalid = 1'b0;
      cpu_rready = bp_en ? lcg_next() > 32'h6000_0000 : 1'b1;
      cpu_bready = bp_en ? lcg_next() > 32'h6000_0000 : 1'b1;
      got = wr ? (cpu_bvalid && cpu_bready) : (cpu_rvalid && cpu_rready);
      if (!got) begin
        @(posedge clock);
        lat++;
        if (lat > 300) abort_on_timeout("cpu response");
      end
    end
    got_data = cpu_rdata;
    got_resp = wr ? cpu_bresp : cpu_rresp;
    @(posedge clock);
    check_resp(wr ? "cpu_bresp" : "cpu_rresp", got_resp, exp_resp);
    if (!wr && !err) check_data("cpu_rdata", got_data, shadow[widx]);
    if (rd_count - reads0 != ((hw < 0) ? 1 : 0)) begin
      report_wrong($sformatf("wrong number of memory reads for address %h", addr));
    end else if (hw < 0) begin
      check_addr("mem_araddr", rd_addr, {addr[15:3], 3'b000});
    end
    if (wb_addr_q.size() != (exp_wb ? 1 : 0)) begin
      report_wrong($sformatf("wrong number of memory writes for address %h", addr));
    end else if (exp_wb) begin
      check_addr("mem_awaddr", wb_addr_q[0], wb_addr);
      check_data("mem_wdata", wb_data_q[0], shadow[wb_addr[15:3]]);
      // a writeback always carries the whole line
      check_strb("mem_wstrb", wb_strb_q[0], {strb_bits{1'b1}});
    end
    // reference update
    if (hw >= 0) begin
      if (wr) begin
        shadow[widx] = apply_strobe(shadow[widx], data, strb);
        m_dirty[s][hw] = 1'b1;
      end
    end else if (!err) begin
      m_valid[s][v] = 1'b1;
      m_dirty[s][v] = wr;
      m_tag[s][v] = tag;
      advance_tree(s);
      if (wr) shadow[widx] = apply_strobe(shadow[widx], data, strb);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name,
             (errors == test_start_errors) ? "ok" : "errors seen");
    test_start_errors = errors;
  endtask

  initial begin
    int lat;
    logic [31:0] r;
    logic [addr_bits-1:0] a;
    seed = 32'd62648;
    for (int i = 0; i < 8192; i++) begin
      mem_words[i] = init_word(13'(i));
      shadow[i] = init_word(13'(i));
    end
    for (int s = 0; s < num_set; s++) begin
      p_root[s] = 1'b0;
      p_left[s] = 1'b0;
      p_right[s] = 1'b0;
      for (int w = 0; w < num_way; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w] = '0;
      end
    end
    reset = 1'b1;
    cpu_araddr = '0;
    cpu_arvalid = 1'b0;
    cpu_rready = 1'b1;
    cpu_awaddr = '0;
    cpu_awvalid = 1'b0;
    cpu_wdata = '0;
    cpu_wstrb = '0;
    cpu_wvalid = 1'b0;
    cpu_bready = 1'b1;
    err_en = 1'b0;
    err_word = '0;
    bp_en = 1'b0;
    rd_count = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    test_start_errors = 0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    do_access(1'b0, 16'h0108, '0, '0, lat);
    do_access(1'b0, 16'h010c, '0, '0, lat);
    if (lat != 2) report_wrong($sformatf("read hit took %0d cycles, expected 2", lat));
    end_test("read miss then hit");

    r = lcg_next();
    do_access(1'b1, 16'h0108, {lcg_next(), lcg_next()}, r[7:0], lat);
    if (lat != 3) report_wrong($sformatf("write hit took %0d cycles, expected 3", lat));
    do_access(1'b0, 16'h0108, '0, '0, lat);
    end_test("write hit merge");

    // tags 1..6 in set 2, alternating dirty and clean fills
    for (int t = 1; t <= 6; t++) begin
      a = {10'(t), 3'd2, 3'd0};
      do_access(t % 2 == 1, a, {lcg_next(), lcg_next()}, 8'h3c, lat);
    end
    end_test("pseudo-LRU fill and eviction");

    do_access(1'b1, 16'h02e8, 64'h0123_4567_89ab_cdef, 8'ha5, lat);
    for (int t = 1; t <= 4; t++) begin
      do_access(1'b0, {10'(t + 32), 3'd5, 3'd0}, '0, '0, lat);
    end
    end_test("write miss allocate and writeback");

    err_en = 1'b1;
    err_word = 13'h0742;
    do_access(1'b0, 16'h3a10, '0, '0, lat);
    err_en = 1'b0;
    do_access(1'b0, 16'h3a10, '0, '0, lat);
    err_en = 1'b1;
    err_word = 13'h0153;
    do_access(1'b1, 16'h0a98, 64'hffff_0000_ffff_0000, 8'hff, lat);
    err_en = 1'b0;
    end_test("refill error response");

    bp_en = 1'b1;
    repeat (80) begin
      r = lcg_next();
      a = {7'b0, r[2:0], r[5:3], r[8:6]};
      do_access(r[20], a, {lcg_next(), lcg_next()}, r[16:9], lat);
    end
    bp_en = 1'b0;
    end_test("random mix with back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dcache.f
common/cache_pkg.sv
common/axil_pkg.sv
dcache/cache_way.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_chk.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
# The exit status is nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation returned status $run_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1
